// File: build.f
design/lsu_pkg.sv
design/lsu_agen.sv
design/lsu_addrcheck.sv
design/lsu_dccm.sv
design/lsu_result.sv
design/lsu_ctl.sv
dv/lsu_ctl_assert.sv
dv/lsu_ctl_checker.sv
dv/lsu_ctl_tb.sv

// File: design/lsu_addrcheck.sv
//************************************************
// DC2 memory map check stage
// DCCM region decode of start and end address,
// access fault and misaligned fault
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_addrcheck (
   input  logic               clk,
   input  logic               reset,
   input  logic               in_valid,
   output logic               in_ready,
   input  lsu_pkg::lsu_agen_t in,
   output logic               out_valid,
   input  logic               out_ready,
   output lsu_pkg::lsu_chk_t  out
);
   import lsu_pkg::*;

   logic start_in_dccm;
   logic end_in_dccm;
   logic misaligned;
   logic access_fault;

   function automatic logic addr_in_dccm(addr_t a);
      return (a >= DCCM_BASE) && (a <= DCCM_BASE + addr_t'(DCCM_BYTES - 1));
   endfunction

   assign start_in_dccm = addr_in_dccm(in.addr);
   assign end_in_dccm   = addr_in_dccm(in.end_addr);

   // Natural alignment per size
   always_comb begin
      case (in.size)
         SIZE_BYTE: misaligned = 1'b0;
         SIZE_HALF: misaligned = in.addr[0];
         default:   misaligned = |in.addr[1:0];
      endcase
   end

   // Misaligned takes priority over access
   assign access_fault = ~misaligned & ~(start_in_dccm & end_in_dccm);

   //************************************************
   // Stage register
   //************************************************
   assign in_ready = ~out_valid | out_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out.store            <= in.store;
         out.unsign           <= in.unsign;
         out.size             <= in.size;
         out.addr             <= in.addr;
         out.store_data       <= in.store_data;
         out.access_fault     <= access_fault;
         out.misaligned_fault <= misaligned;
      end
   end

endmodule

`default_nettype wire

// File: design/lsu_agen.sv
//************************************************
// DC1 address generation stage
// Start address from base plus signed offset,
// end address from the access size
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_agen (
   input  logic               clk,
   input  logic               reset,
   input  logic               in_valid,
   output logic               in_ready,
   input  lsu_pkg::lsu_req_t  in,
   output logic               out_valid,
   input  logic               out_ready,
   output lsu_pkg::lsu_agen_t out
);
   import lsu_pkg::*;

   logic [1:0]  size_m1;
   logic [12:0] end_offset;
   addr_t       start_addr;
   addr_t       end_addr;

   // Bytes beyond the first one, word for the unused encoding
   always_comb begin
      case (in.size)
         SIZE_BYTE: size_m1 = 2'd0;
         SIZE_HALF: size_m1 = 2'd1;
         default:   size_m1 = 2'd3;
      endcase
   end

   assign start_addr = in.rs1 + {{20{in.offset[11]}}, in.offset};

   // Size folded into the offset first, then sign extended onto the base
   assign end_offset = {in.offset[11], in.offset} + {11'b0, size_m1};
   assign end_addr   = in.rs1 + {{19{end_offset[12]}}, end_offset};

   //************************************************
   // Stage register
   //************************************************
   assign in_ready = ~out_valid | out_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out.store      <= in.store;
         out.unsign     <= in.unsign;
         out.size       <= in.size;
         out.addr       <= start_addr;
         out.end_addr   <= end_addr;
         out.store_data <= in.store_data;
      end
   end

endmodule

`default_nettype wire

// File: design/lsu_ctl.sv
//************************************************
// Load/store control top level
// DC1 agen, DC2 check, DC3 DCCM, DC4 result
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl (
   input  logic               clk,
   input  logic               reset,
   input  logic               req_valid,
   output logic               req_ready,
   input  lsu_pkg::lsu_req_t  req,
   output logic               resp_valid,
   input  logic               resp_ready,
   output lsu_pkg::lsu_resp_t resp
);
   import lsu_pkg::*;

   // DC1 to DC2
   logic      agen_valid;
   logic      agen_ready;
   lsu_agen_t agen_pkt;

   // DC2 to DC3
   logic      chk_valid;
   logic      chk_ready;
   lsu_chk_t  chk_pkt;

   // DC3 to DC4
   logic      mem_valid;
   logic      mem_ready;
   lsu_mem_t  mem_pkt;

   lsu_agen agen_i (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (req_valid),
      .in_ready  (req_ready),
      .in        (req),
      .out_valid (agen_valid),
      .out_ready (agen_ready),
      .out       (agen_pkt)
   );

   lsu_addrcheck addrcheck_i (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (agen_valid),
      .in_ready  (agen_ready),
      .in        (agen_pkt),
      .out_valid (chk_valid),
      .out_ready (chk_ready),
      .out       (chk_pkt)
   );

   lsu_dccm dccm_i (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (chk_valid),
      .in_ready  (chk_ready),
      .in        (chk_pkt),
      .out_valid (mem_valid),
      .out_ready (mem_ready),
      .out       (mem_pkt)
   );

   lsu_result result_i (
      .clk       (clk),
      .reset     (reset),
      .in_valid  (mem_valid),
      .in_ready  (mem_ready),
      .in        (mem_pkt),
      .out_valid (resp_valid),
      .out_ready (resp_ready),
      .out       (resp)
   );

endmodule

`default_nettype wire

// File: design/lsu_dccm.sv
//************************************************
// DC3 memory access stage
// On-chip DCCM array, byte lane store write
// and aligned load read
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_dccm (
   input  logic              clk,
   input  logic              reset,
   input  logic              in_valid,
   output logic              in_ready,
   input  lsu_pkg::lsu_chk_t in,
   output logic              out_valid,
   input  logic              out_ready,
   output lsu_pkg::lsu_mem_t out
);
   import lsu_pkg::*;

   data_t       mem [DCCM_WORDS];
   dccm_index_t index;
   byte_en_t    byte_en;
   data_t       wr_data;
   data_t       rd_data;
   logic [4:0]  lane_shift;
   logic        fault;
   logic        accept;
   logic        do_write;
   logic        do_read;

   assign index      = in.addr[9:2];
   assign lane_shift = {in.addr[1:0], 3'b000};
   assign fault      = in.access_fault | in.misaligned_fault;
   assign accept     = in_valid & in_ready;
   assign do_write   = accept & in.store & ~fault;
   assign do_read    = ~in.store & ~fault;

   // Lanes touched by the access
   always_comb begin
      case (in.size)
         SIZE_BYTE: byte_en = byte_en_t'(4'b0001 << in.addr[1:0]);
         SIZE_HALF: byte_en = byte_en_t'(4'b0011 << in.addr[1:0]);
         default:   byte_en = 4'b1111;
      endcase
   end

   // Store data moved up to its lanes
   assign wr_data = in.store_data << lane_shift;
   assign rd_data = mem[index] >> lane_shift;

   //************************************************
   // DCCM array
   //************************************************
   always_ff @(posedge clk) begin
      if (do_write) begin
         for (int i = 0; i < 4; i++) begin
            if (byte_en[i]) begin
               mem[index][8*i +: 8] <= wr_data[8*i +: 8];
            end
         end
      end
   end

   //************************************************
   // Stage register
   //************************************************
   assign in_ready = ~out_valid | out_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // Read sees the array before this edge, so all older stores are in it
   always_ff @(posedge clk) begin
      if (accept) begin
         out.store            <= in.store;
         out.unsign           <= in.unsign;
         out.size             <= in.size;
         out.addr             <= in.addr;
         out.load_raw         <= do_read ? rd_data : '0;
         out.access_fault     <= in.access_fault;
         out.misaligned_fault <= in.misaligned_fault;
      end
   end

endmodule

`default_nettype wire

// File: design/lsu_pkg.sv
//************************************************
// Shared definitions for the load/store pipeline
// Widths, DCCM memory map, access size encoding
// and the packets passed between DC1 and DC4
//************************************************
`default_nettype none

package lsu_pkg;

   // Widths that carry a meaning
   typedef logic [31:0]        addr_t;
   typedef logic [31:0]        data_t;
   typedef logic signed [11:0] offset_t;
   typedef logic [7:0]         dccm_index_t;
   typedef logic [3:0]         byte_en_t;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } lsu_size_e;

   //************************************************
   // Memory map
   //************************************************
   localparam addr_t DCCM_BASE  = 32'hF004_0000;
   localparam int    DCCM_WORDS = 256;
   localparam int    DCCM_BYTES = 1024;

   //************************************************
   // Stage packets
   //************************************************
   typedef struct packed {
      logic      store;
      logic      unsign;
      lsu_size_e size;
      addr_t     rs1;
      offset_t   offset;
      data_t     store_data;
   } lsu_req_t;

   // DC1 output
   typedef struct packed {
      logic      store;
      logic      unsign;
      lsu_size_e size;
      addr_t     addr;
      addr_t     end_addr;
      data_t     store_data;
   } lsu_agen_t;

   // DC2 output
   typedef struct packed {
      logic      store;
      logic      unsign;
      lsu_size_e size;
      addr_t     addr;
      data_t     store_data;
      logic      access_fault;
      logic      misaligned_fault;
   } lsu_chk_t;

   // DC3 output, load word already aligned to bit 0
   typedef struct packed {
      logic      store;
      logic      unsign;
      lsu_size_e size;
      addr_t     addr;
      data_t     load_raw;
      logic      access_fault;
      logic      misaligned_fault;
   } lsu_mem_t;

   typedef struct packed {
      data_t     load_data;
      logic      is_store;
      logic      exc_valid;
      logic      exc_misaligned;
      addr_t     addr;
   } lsu_resp_t;

endpackage

`default_nettype wire

// File: design/lsu_result.sv
//************************************************
// DC4 result formatting stage
// Load zero/sign extension, response and
// exception packet
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_result (
   input  logic               clk,
   input  logic               reset,
   input  logic               in_valid,
   output logic               in_ready,
   input  lsu_pkg::lsu_mem_t  in,
   output logic               out_valid,
   input  logic               out_ready,
   output lsu_pkg::lsu_resp_t out
);
   import lsu_pkg::*;

   data_t ext_data;
   logic  fault;

   always_comb begin
      case (in.size)
         SIZE_BYTE: ext_data = in.unsign ? {24'b0, in.load_raw[7:0]} :
                                           {{24{in.load_raw[7]}}, in.load_raw[7:0]};
         SIZE_HALF: ext_data = in.unsign ? {16'b0, in.load_raw[15:0]} :
                                           {{16{in.load_raw[15]}}, in.load_raw[15:0]};
         default:   ext_data = in.load_raw;
      endcase
   end

   assign fault = in.access_fault | in.misaligned_fault;

   //************************************************
   // Stage register
   //************************************************
   assign in_ready = ~out_valid | out_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
      end else if (in_ready) begin
         out_valid <= in_valid;
      end
   end

   // Stores and faulting accesses return no data
   always_ff @(posedge clk) begin
      if (in_valid && in_ready) begin
         out.load_data      <= (in.store || fault) ? '0 : ext_data;
         out.is_store       <= in.store;
         out.exc_valid      <= fault;
         out.exc_misaligned <= in.misaligned_fault;
         out.addr           <= in.addr;
      end
   end

endmodule

`default_nettype wire

// File: dv/lsu_ctl_assert.sv
//************************************************
// Handshake and response assertions for the
// load/store pipeline, bound to the top level
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl_assert (
   input logic               clk,
   input logic               reset,
   input logic               resp_valid,
   input logic               resp_ready,
   input lsu_pkg::lsu_resp_t resp
);
   import lsu_pkg::*;

   // A stalled response holds until it is taken
   resp_stable_a: assert property (@(posedge clk) disable iff (reset)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp))
      else $error("resp or resp_valid changed while stalled");

   no_data_on_exc_a: assert property (@(posedge clk) disable iff (reset)
      resp_valid && resp.exc_valid |-> resp.load_data == '0)
      else $error("load_data not zero with exc_valid set");

   idle_after_reset_a: assert property (@(posedge clk) reset |=> !resp_valid)
      else $error("resp_valid high in the cycle after reset");

endmodule

bind lsu_ctl lsu_ctl_assert assert_i (
   .clk        (clk),
   .reset      (reset),
   .resp_valid (resp_valid),
   .resp_ready (resp_ready),
   .resp       (resp)
);

`default_nettype wire

// File: dv/lsu_ctl_checker.sv
//************************************************
// Response checker for the load/store pipeline
// DCCM model, expected response queue, compare
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl_checker (
   input  logic               clk,
   input  logic               reset,
   input  logic               req_valid,
   input  logic               req_ready,
   input  lsu_pkg::lsu_req_t  req,
   input  logic               resp_valid,
   input  logic               resp_ready,
   input  lsu_pkg::lsu_resp_t resp,
   output int                 error_count,
   output int                 resp_count,
   output int                 pending
);
   import lsu_pkg::*;

   data_t     model [DCCM_WORDS];
   lsu_resp_t expected_q [$];

   function automatic logic in_dccm(addr_t a);
      return (a - DCCM_BASE) < addr_t'(DCCM_BYTES);
   endfunction

   // Expected response of one request, model updated in request order
   function automatic lsu_resp_t predict(lsu_req_t r);
      lsu_resp_t   e;
      addr_t       start;
      dccm_index_t idx;
      int          nbytes;
      int          lane;
      logic        mis;
      nbytes = (r.size == SIZE_BYTE) ? 1 : (r.size == SIZE_HALF) ? 2 : 4;
      start  = r.rs1 + {{20{r.offset[11]}}, r.offset};
      idx    = start[9:2];
      lane   = int'(start[1:0]);
      mis    = (nbytes == 2 && start[0]) || (nbytes == 4 && start[1:0] != 2'b00);
      e                = '0;
      e.addr           = start;
      e.is_store       = r.store;
      e.exc_misaligned = mis;
      e.exc_valid      = mis || !in_dccm(start) || !in_dccm(start + addr_t'(nbytes - 1));
      if (!e.exc_valid) begin
         for (int b = 0; b < nbytes; b++) begin
            if (r.store) model[idx][8*(lane+b) +: 8] = r.store_data[8*b +: 8];
            else e.load_data[8*b +: 8] = model[idx][8*(lane+b) +: 8];
         end
         // Fill the upper bytes with the sign of a signed narrow load
         if (!r.store && !r.unsign && nbytes < 4 && e.load_data[8*nbytes-1]) begin
            for (int b = nbytes; b < 4; b++) e.load_data[8*b +: 8] = 8'hff;
         end
      end
      return e;
   endfunction

   task automatic compare_field(string name, logic [31:0] exp, logic [31:0] act);
      if (exp !== act) begin
         $display("Error: %s expected %h actual %h", name, exp, act);
         error_count++;
      end
   endtask

   //************************************************
   // Compare on response, predict on request
   //************************************************
   always @(posedge clk) begin
      lsu_resp_t e;
      if (reset) begin
         error_count = 0;
         resp_count  = 0;
         expected_q.delete();
      end else begin
         if (resp_valid && resp_ready) begin
            resp_count++;
            if (expected_q.size() == 0) begin
               $display("A response for address %h came with no request outstanding",
                        resp.addr);
               error_count++;
            end else begin
               e = expected_q.pop_front();
               compare_field("resp.load_data", e.load_data, resp.load_data);
               compare_field("resp.is_store", 32'(e.is_store), 32'(resp.is_store));
               compare_field("resp.exc_valid", 32'(e.exc_valid), 32'(resp.exc_valid));
               compare_field("resp.exc_misaligned", 32'(e.exc_misaligned),
                             32'(resp.exc_misaligned));
               compare_field("resp.addr", e.addr, resp.addr);
            end
         end
         if (req_valid && req_ready) expected_q.push_back(predict(req));
      end
      pending = expected_q.size();
   end

endmodule

`default_nettype wire

// File: dv/lsu_ctl_tb.sv
//************************************************
// Testbench top for the load/store pipeline
// Clock, reset, LFSR stimulus, timeout, result
//************************************************
`timescale 1ns/1ps
`default_nettype none

module lsu_ctl_tb;
   import lsu_pkg::*;

   localparam int FILL_REQS   = DCCM_WORDS;
   localparam int TOTAL_REQS  = 600;
   localparam int CYCLE_LIMIT = TOTAL_REQS * 20;

   logic        clk = 1'b0;
   logic        reset;
   logic        req_valid;
   logic        req_ready;
   lsu_req_t    req;
   logic        resp_valid;
   logic        resp_ready;
   lsu_resp_t   resp;
   int          error_count;
   int          resp_count;
   int          pending;
   int          cycle_count = 0;
   logic [31:0] lfsr_state = 32'hc7f0498d;

   always #5 clk = ~clk;

   lsu_ctl dut_i (.*);
   lsu_ctl_checker checker_i (.*);

   function automatic logic [31:0] lfsr_step(logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   function automatic logic [31:0] take_bits(int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         v          = {v[30:0], lfsr_state[0]};
         lfsr_state = lfsr_step(lfsr_state);
      end
      return v;
   endfunction

   // Word store of a pattern that depends on the whole address
   function automatic lsu_req_t fill_req(int n);
      lsu_req_t r;
      r            = '0;
      r.store      = 1'b1;
      r.size       = SIZE_WORD;
      r.rs1        = DCCM_BASE + addr_t'(4 * n);
      r.store_data = r.rs1 ^ {r.rs1[11:0], r.rs1[31:12]} ^ 32'h5a5a_c3c3;
      return r;
   endfunction

   function automatic lsu_req_t random_req();
      lsu_req_t    r;
      addr_t       target;
      logic [1:0]  sz;
      r.store      = take_bits(1) != 0;
      r.unsign     = take_bits(1) != 0;
      sz           = 2'(take_bits(2));
      r.size       = (sz == 2'd3) ? SIZE_WORD : lsu_size_e'(sz);
      r.store_data = take_bits(32);
      r.offset     = offset_t'(take_bits(12));
      case (3'(take_bits(3)))
         3'd0:    target = take_bits(32);
         3'd1:    target = DCCM_BASE + addr_t'(DCCM_BYTES - 4) + take_bits(3);
         3'd2:    target = DCCM_BASE - 32'd8 + take_bits(3);
         default: target = DCCM_BASE + take_bits(10);
      endcase
      // Mostly aligned, so that loads and stores reach the DCCM
      if (take_bits(2) != 0) begin
         if (r.size == SIZE_HALF) target[0] = 1'b0;
         if (r.size == SIZE_WORD) target[1:0] = 2'b00;
      end
      r.rs1 = target - {{20{r.offset[11]}}, r.offset};
      return r;
   endfunction

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles with %0d responses received",
                  cycle_count, resp_count);
         $display("Checks failed");
         $finish;
      end
   end

   //************************************************
   // Stimulus, fill phase then random phase
   //************************************************
   initial begin
      int   sent;
      int   waited;
      logic taken;
      sent       = 0;
      waited     = 0;
      reset      = 1'b1;
      req_valid  = 1'b0;
      req        = '0;
      resp_ready = 1'b0;
      repeat (4) @(posedge clk);
      #1;
      reset = 1'b0;
      while (sent < TOTAL_REQS) begin
         resp_ready = (sent < FILL_REQS) || (take_bits(2) != 0);
         if (!req_valid && (sent < FILL_REQS || take_bits(2) != 0)) begin
            req       = (sent < FILL_REQS) ? fill_req(sent) : random_req();
            req_valid = 1'b1;
         end
         @(negedge clk);
         taken = req_valid && req_ready;
         @(posedge clk);
         #1;
         if (taken) begin
            req_valid = 1'b0;
            sent++;
         end
      end
      resp_ready = 1'b1;
      while (pending != 0 && waited < 50) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (pending != 0) $display("%0d requests never received a response", pending);
      $display("Summary: %0d errors, %0d responses, %0d requests outstanding",
               error_count, resp_count, pending);
      if (error_count == 0 && pending == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Compile and run the load/store pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 -f build.f --top-module lsu_ctl_tb
output=$(./obj_dir/Vlsu_ctl_tb)
echo "$output"

if echo "$output" | grep -q "All checks passed"; then
   exit 0
fi
exit 1
